// File: rtl/rom_loader_config.svh
// ROM loader widths and sizes
`ifndef ROM_LOADER_CONFIG_SVH
`define ROM_LOADER_CONFIG_SVH

// Byte address width of the SDRAM port, whose low bit is always clear
`define SDR_ADDR_W 25

// Byte address width of the DDR port
`define DDR_ADDR_W 32

// Byte address width of the block RAM write port
`define BRAM_ADDR_W 24

// Entries in the region table, indexed by the low bits of the index byte
`define NUM_REGIONS 8

`endif

// File: rtl/rom_loader_pkg.sv
// ROM loader types and region table
`default_nettype none

`include "rom_loader_config.svh"

package rom_loader_pkg;

    // Which memory a region is stored in, and so how its payload is packed
    typedef enum logic [1:0] {
        STORAGE_SDR  = 2'd0,
        STORAGE_DDR  = 2'd1,
        STORAGE_BRAM = 2'd2
    } storage_t;

    typedef struct packed {
        logic [31:0] base_addr;
        storage_t    storage;
    } region_t;

    // The first two bytes of the stream, first byte in the high half
    typedef struct packed {
        logic [7:0] game_id;
        logic [3:0] region_mask;
        logic [3:0] flags;
    } board_cfg_t;

    // =========================================================================
    // Region table
    // =========================================================================

    // Program and sprite data go to SDRAM, sample and tile data to DDR,
    // and the small lookup PROMs to block RAM
    localparam region_t LOAD_REGIONS [`NUM_REGIONS] = '{
        '{base_addr: 32'h0000_0000, storage: STORAGE_SDR},
        '{base_addr: 32'h0010_0000, storage: STORAGE_SDR},
        '{base_addr: 32'h3000_0000, storage: STORAGE_DDR},
        '{base_addr: 32'h0000_0000, storage: STORAGE_BRAM},
        '{base_addr: 32'h0000_4000, storage: STORAGE_BRAM},
        '{base_addr: 32'h3010_0000, storage: STORAGE_DDR},
        '{base_addr: 32'h3020_0000, storage: STORAGE_DDR},
        '{base_addr: 32'h3030_0000, storage: STORAGE_DDR}
    };

endpackage

`default_nettype wire

// File: rtl/load_stream_if.sv
// Payload byte stream to a packing writer
`timescale 1ns/1ps
`default_nettype none

interface load_stream_if;

    // One cycle per payload byte, only while busy is low
    logic        strobe;
    logic [7:0]  data;

    // Full byte address, region base plus offset
    logic [31:0] addr;

    // High from the cycle after a word completes until its memory write ends
    logic        busy;

    modport parser (
        output strobe,
        output data,
        output addr,
        input  busy
    );

    modport writer (
        input  strobe,
        input  data,
        input  addr,
        output busy
    );

endinterface

`default_nettype wire

// File: rtl/load_header_parser.sv
// ROM download header parser
`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_config.svh"

module load_header_parser (
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      ioctl_wr,
    input  wire logic [7:0]                ioctl_data,
    output logic                           ioctl_wait,

    load_stream_if.parser                  sdr_stream,
    load_stream_if.parser                  ddr_stream,

    output logic [`BRAM_ADDR_W-1:0]        bram_addr,
    output logic [7:0]                     bram_data,
    output logic                           bram_wr,

    output rom_loader_pkg::board_cfg_t     board_cfg
);

    localparam int REGION_W = $clog2(`NUM_REGIONS);

    typedef enum logic [2:0] {
        ST_CFG_0,
        ST_CFG_1,
        ST_REGION_IDX,
        ST_SIZE_0,
        ST_SIZE_1,
        ST_SIZE_2,
        ST_PAYLOAD
    } stage_t;

    stage_t                     stage;
    logic [REGION_W-1:0]        region_idx;
    logic [7:0]                 cfg_hi;
    logic [23:0]                size;
    logic [23:0]                offset;
    logic [23:0]                offset_next;
    logic [31:0]                base_addr;
    rom_loader_pkg::storage_t   storage;
    logic [31:0]                payload_addr;
    logic                       payload_wr;
    logic                       size_zero;

    assign payload_wr   = ioctl_wr && (stage == ST_PAYLOAD);
    assign offset_next  = offset + 24'd1;
    assign payload_addr = base_addr + {8'd0, offset};
    assign size_zero    = ({size[23:8], ioctl_data} == 24'd0);

    // =========================================================================
    // Header stages
    // =========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= ST_CFG_0;
            region_idx <= '0;
            board_cfg  <= '0;
        end else if (ioctl_wr) begin
            case (stage)
                ST_CFG_0: stage <= ST_CFG_1;
                ST_CFG_1: begin
                    board_cfg <= rom_loader_pkg::board_cfg_t'({cfg_hi, ioctl_data});
                    stage     <= ST_REGION_IDX;
                end
                ST_REGION_IDX: begin
                    // 0xFF continues with the region after the previous one
                    if (ioctl_data == 8'hff) begin
                        region_idx <= region_idx + REGION_W'(1);
                    end else begin
                        region_idx <= ioctl_data[REGION_W-1:0];
                    end
                    stage <= ST_SIZE_0;
                end
                ST_SIZE_0: stage <= ST_SIZE_1;
                ST_SIZE_1: stage <= ST_SIZE_2;
                ST_SIZE_2: stage <= size_zero ? ST_REGION_IDX : ST_PAYLOAD;
                ST_PAYLOAD: begin
                    if (offset_next == size) begin
                        stage <= ST_REGION_IDX;
                    end
                end
                default: stage <= ST_CFG_0;
            endcase
        end
    end

    // Size, region lookup and byte count
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            case (stage)
                ST_CFG_0:  cfg_hi       <= ioctl_data;
                ST_SIZE_0: size[23:16]  <= ioctl_data;
                ST_SIZE_1: size[15:8]   <= ioctl_data;
                ST_SIZE_2: begin
                    size[7:0] <= ioctl_data;
                    base_addr <= rom_loader_pkg::LOAD_REGIONS[region_idx].base_addr;
                    storage   <= rom_loader_pkg::LOAD_REGIONS[region_idx].storage;
                    offset    <= 24'd0;
                end
                ST_PAYLOAD: offset <= offset_next;
                default: ;
            endcase
        end
    end

    // =========================================================================
    // Payload routing
    // =========================================================================

    // Block RAM takes bytes directly, one cycle after the host strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            bram_wr <= 1'b0;
        end else begin
            bram_wr <= payload_wr && (storage == rom_loader_pkg::STORAGE_BRAM);
        end
    end

    always_ff @(posedge clk) begin
        if (payload_wr) begin
            bram_addr <= payload_addr[`BRAM_ADDR_W-1:0];
            bram_data <= ioctl_data;
        end
    end

    assign sdr_stream.strobe = payload_wr && (storage == rom_loader_pkg::STORAGE_SDR);
    assign sdr_stream.data   = ioctl_data;
    assign sdr_stream.addr   = payload_addr;

    assign ddr_stream.strobe = payload_wr && (storage == rom_loader_pkg::STORAGE_DDR);
    assign ddr_stream.data   = ioctl_data;
    assign ddr_stream.addr   = payload_addr;

    // The host is held off while either writer is storing a word
    assign ioctl_wait = sdr_stream.busy | ddr_stream.busy;

    // The host respects the stall for as long as a writer holds it
    a_no_wr_during_wait: assert property (
        @(posedge clk) disable iff (reset) ioctl_wait |-> !ioctl_wr
    );

    // A writer never receives a byte while it is still storing a word
    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        !(sdr_stream.strobe && sdr_stream.busy) && !(ddr_stream.strobe && ddr_stream.busy)
    );

endmodule

`default_nettype wire

// File: rtl/sdr_word_writer.sv
// SDRAM 16-bit word writer
`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_config.svh"

module sdr_word_writer (
    input  wire logic                    clk,
    input  wire logic                    reset,

    load_stream_if.writer                stream,

    output logic [`SDR_ADDR_W-1:0]       sdr_addr,
    output logic [15:0]                  sdr_data,
    output logic                         sdr_req,
    input  wire logic                    sdr_ack
);

    logic [7:0] low_byte;
    logic       pending;

    // The even byte waits here for its partner
    always_ff @(posedge clk) begin
        if (stream.strobe && !stream.addr[0]) begin
            low_byte <= stream.data;
        end
    end

    always_ff @(posedge clk) begin
        if (stream.strobe && stream.addr[0]) begin
            sdr_addr <= {stream.addr[`SDR_ADDR_W-1:1], 1'b0};
            sdr_data <= {stream.data, low_byte};
        end
    end

    // A request is a toggle of sdr_req and ends when sdr_ack catches up
    always_ff @(posedge clk) begin
        if (reset) begin
            sdr_req <= 1'b0;
            pending <= 1'b0;
        end else if (stream.strobe && stream.addr[0]) begin
            sdr_req <= ~sdr_req;
            pending <= 1'b1;
        end else if (pending && (sdr_req == sdr_ack)) begin
            pending <= 1'b0;
        end
    end

    assign stream.busy = pending;

    // The controller may sample the request at any point until it acknowledges
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (pending && $past(pending)) |-> ($stable(sdr_addr) && $stable(sdr_data) &&
                                         $stable(sdr_req))
    );

endmodule

`default_nettype wire

// File: rtl/ddr_beat_writer.sv
// DDR 64-bit beat writer
`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_config.svh"

module ddr_beat_writer (
    input  wire logic                    clk,
    input  wire logic                    reset,

    load_stream_if.writer                stream,

    output logic                         ddr_acquire,
    input  wire logic                    ddr_busy,
    output logic [`DDR_ADDR_W-1:0]       ddr_addr,
    output logic [63:0]                  ddr_wdata,
    output logic                         ddr_write
);

    typedef enum logic [1:0] {
        ST_COLLECT,
        ST_ISSUE,
        ST_FINISH
    } state_t;

    state_t      state;
    logic [63:0] beat;
    logic        beat_done;

    assign beat_done = stream.strobe && (stream.addr[2:0] == 3'd7);

    // Byte k of the beat goes to lane k
    always_ff @(posedge clk) begin
        if (stream.strobe) begin
            beat[8*stream.addr[2:0] +: 8] <= stream.data;
        end
        if (beat_done) begin
            ddr_addr <= {stream.addr[`DDR_ADDR_W-1:3], 3'b000};
        end
        if (state == ST_ISSUE && !ddr_busy) begin
            ddr_wdata <= beat;
        end
    end

    // =========================================================================
    // Acquire, write and wait
    // =========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_COLLECT;
            ddr_acquire <= 1'b0;
            ddr_write   <= 1'b0;
        end else begin
            ddr_write <= 1'b0;
            case (state)
                ST_COLLECT: begin
                    if (beat_done) begin
                        ddr_acquire <= 1'b1;
                        state       <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (!ddr_busy) begin
                        ddr_write <= 1'b1;
                        state     <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    // The write is accepted once busy is seen low after it
                    if (!ddr_busy) begin
                        ddr_acquire <= 1'b0;
                        state       <= ST_COLLECT;
                    end
                end
                default: state <= ST_COLLECT;
            endcase
        end
    end

    assign stream.busy = (state != ST_COLLECT);

    // The port is only written while it is held, and no byte lands in the beat during the write
    a_write_in_acquire: assert property (
        @(posedge clk) disable iff (reset)
        ddr_write |-> (ddr_acquire && $stable(ddr_addr) && (ddr_wdata == beat))
    );

endmodule

`default_nettype wire

// File: rtl/rom_loader_top.sv
// ROM download path top level
`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_config.svh"

module rom_loader_top (
    input  wire logic                    clk,
    input  wire logic                    reset,

    // Host download stream
    input  wire logic                    ioctl_wr,
    input  wire logic [7:0]              ioctl_data,
    output logic                         ioctl_wait,

    // SDRAM write port
    output logic [`SDR_ADDR_W-1:0]       sdr_addr,
    output logic [15:0]                  sdr_data,
    output logic                         sdr_req,
    input  wire logic                    sdr_ack,

    // DDR write port
    output logic                         ddr_acquire,
    input  wire logic                    ddr_busy,
    output logic [`DDR_ADDR_W-1:0]       ddr_addr,
    output logic [63:0]                  ddr_wdata,
    output logic                         ddr_write,

    // Block RAM write port
    output logic [`BRAM_ADDR_W-1:0]      bram_addr,
    output logic [7:0]                   bram_data,
    output logic                         bram_wr,

    output logic [15:0]                  board_cfg
);

    load_stream_if sdr_stream ();
    load_stream_if ddr_stream ();

    load_header_parser u_parser (
        .clk        (clk),
        .reset      (reset),
        .ioctl_wr   (ioctl_wr),
        .ioctl_data (ioctl_data),
        .ioctl_wait (ioctl_wait),
        .sdr_stream (sdr_stream.parser),
        .ddr_stream (ddr_stream.parser),
        .bram_addr  (bram_addr),
        .bram_data  (bram_data),
        .bram_wr    (bram_wr),
        .board_cfg  (board_cfg)
    );

    sdr_word_writer u_sdr (
        .clk      (clk),
        .reset    (reset),
        .stream   (sdr_stream.writer),
        .sdr_addr (sdr_addr),
        .sdr_data (sdr_data),
        .sdr_req  (sdr_req),
        .sdr_ack  (sdr_ack)
    );

    ddr_beat_writer u_ddr (
        .clk         (clk),
        .reset       (reset),
        .stream      (ddr_stream.writer),
        .ddr_acquire (ddr_acquire),
        .ddr_busy    (ddr_busy),
        .ddr_addr    (ddr_addr),
        .ddr_wdata   (ddr_wdata),
        .ddr_write   (ddr_write)
    );

endmodule

`default_nettype wire

// File: verif/tb_rom_loader.sv
// ROM loader directed testbench
`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_config.svh"

module tb_rom_loader;

    localparam realtime PERIOD = 4.0;
    // About 90 bytes in all, each at most a few gap cycles plus a memory stall
    localparam int MAX_CYCLES = 20000;

    logic                   clk;
    logic                   reset;
    logic                   ioctl_wr;
    logic [7:0]             ioctl_data;
    logic                   ioctl_wait;
    logic [`SDR_ADDR_W-1:0] sdr_addr;
    logic [15:0]            sdr_data;
    logic                   sdr_req;
    logic                   sdr_ack;
    logic                   ddr_acquire;
    logic                   ddr_busy;
    logic [`DDR_ADDR_W-1:0] ddr_addr;
    logic [63:0]            ddr_wdata;
    logic                   ddr_write;
    logic [`BRAM_ADDR_W-1:0] bram_addr;
    logic [7:0]             bram_data;
    logic                   bram_wr;
    logic [15:0]            board_cfg;

    // Logs filled by the memory models
    logic [31:0] sdr_addr_log [$];
    logic [15:0] sdr_data_log [$];
    logic [31:0] ddr_addr_log [$];
    logic [63:0] ddr_data_log [$];
    logic [31:0] bram_addr_log [$];
    logic [7:0]  bram_data_log [$];
    realtime     bram_time_log [$];
    realtime     strobe_times [$];
    logic [7:0]  payload [$];

    int sdr_wait_low;
    int stall_cycles;
    int sdr_delay;
    bit sdr_active = 1'b0;
    int cycle_count;
    int error_count;
    int tests_run;
    int tests_failed;

    rom_loader_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .ioctl_wr    (ioctl_wr),
        .ioctl_data  (ioctl_data),
        .ioctl_wait  (ioctl_wait),
        .sdr_addr    (sdr_addr),
        .sdr_data    (sdr_data),
        .sdr_req     (sdr_req),
        .sdr_ack     (sdr_ack),
        .ddr_acquire (ddr_acquire),
        .ddr_busy    (ddr_busy),
        .ddr_addr    (ddr_addr),
        .ddr_wdata   (ddr_wdata),
        .ddr_write   (ddr_write),
        .bram_addr   (bram_addr),
        .bram_data   (bram_data),
        .bram_wr     (bram_wr),
        .board_cfg   (board_cfg)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ========================================================================
    // Memory models
    // ========================================================================

    // SDRAM answers each toggle request a few cycles later
    always @(posedge clk) begin
        if (sdr_active) begin
            sdr_delay = sdr_delay - 1;
            if (sdr_delay == 0) begin
                sdr_active = 1'b0;
                #0.5;
                sdr_ack = sdr_req;
            end
        end else if (!reset && sdr_req !== sdr_ack) begin
            sdr_addr_log.push_back(32'(sdr_addr));
            sdr_data_log.push_back(sdr_data);
            if (ioctl_wait !== 1'b1) begin
                sdr_wait_low++;
            end
            sdr_delay  = $urandom_range(1, 4);
            sdr_active = 1'b1;
        end
    end

    // DDR logs each beat and stalls at random while it is held
    always @(posedge clk) begin
        if (ddr_write === 1'b1) begin
            if (ddr_acquire !== 1'b1) begin
                $display("FAIL %0t: ddr_write pulsed while ddr_acquire is %b", $time,
                         ddr_acquire);
                error_count++;
            end
            ddr_addr_log.push_back(ddr_addr);
            ddr_data_log.push_back(ddr_wdata);
        end
        #0.5;
        ddr_busy = (ddr_acquire === 1'b1) ? 1'($urandom_range(0, 1)) : 1'b0;
    end

    always @(posedge clk) begin
        if (bram_wr === 1'b1) begin
            bram_addr_log.push_back(32'(bram_addr));
            bram_data_log.push_back(bram_data);
            bram_time_log.push_back($realtime);
        end
        if (ioctl_wait === 1'b1) begin
            stall_cycles++;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ========================================================================
    // Driver and helpers
    // ========================================================================

    task automatic send_byte(input logic [7:0] value);
        repeat ($urandom_range(0, 2)) begin
            @(posedge clk);
            #0.5;
        end
        while (ioctl_wait) begin
            @(posedge clk);
            #0.5;
        end
        ioctl_wr   = 1'b1;
        ioctl_data = value;
        @(posedge clk);
        strobe_times.push_back($realtime);
        #0.5;
        ioctl_wr = 1'b0;
    endtask

    // Index byte, big-endian size, then the payload queue
    task automatic send_region(input logic [7:0] index, input logic [23:0] size);
        send_byte(index);
        send_byte(size[23:16]);
        send_byte(size[15:8]);
        send_byte(size[7:0]);
        strobe_times.delete();
        foreach (payload[i]) begin
            send_byte(payload[i]);
        end
    endtask

    task automatic make_payload(input int n);
        payload.delete();
        repeat (n) begin
            payload.push_back(8'($urandom_range(0, 255)));
        end
    endtask

    task automatic clear_logs();
        sdr_addr_log.delete();
        sdr_data_log.delete();
        ddr_addr_log.delete();
        ddr_data_log.delete();
        bram_addr_log.delete();
        bram_data_log.delete();
        bram_time_log.delete();
        strobe_times.delete();
        sdr_wait_low = 0;
        stall_cycles = 0;
    endtask

    task automatic wait_idle();
        repeat (2) begin
            @(posedge clk);
            #0.5;
        end
        while (ioctl_wait) begin
            @(posedge clk);
            #0.5;
        end
        repeat (2) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ========================================================================
    // Tests
    // ========================================================================

    task automatic test_board_cfg();
        int                         errors_before;
        rom_loader_pkg::board_cfg_t cfg;
        errors_before = error_count;
        send_byte(8'ha5);
        send_byte(8'h3c);
        cfg = rom_loader_pkg::board_cfg_t'(board_cfg);
        if (board_cfg !== 16'ha53c || cfg.game_id !== 8'ha5) begin
            $display("FAIL %0t: board_cfg is %h, expected a53c", $time, board_cfg);
            error_count++;
        end
        report_test("board configuration", errors_before);
    endtask

    task automatic test_bram_region();
        int          errors_before;
        logic [31:0] base;
        errors_before = error_count;
        base = rom_loader_pkg::LOAD_REGIONS[3].base_addr;
        clear_logs();
        make_payload(5);
        send_region(8'd3, 24'd5);
        wait_idle();
        if (bram_addr_log.size() != 5) begin
            $display("FAIL %0t: %0d block RAM writes, expected 5", $time, bram_addr_log.size());
            error_count++;
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (bram_addr_log[i] !== base + i || bram_data_log[i] !== payload[i]) begin
                    $display("FAIL %0t: block RAM write %0d is %h=%h, expected %h=%h", $time, i,
                             bram_addr_log[i], bram_data_log[i], base + i, payload[i]);
                    error_count++;
                end
                if (bram_time_log[i] != strobe_times[i] + PERIOD) begin
                    $display("FAIL %0t: block RAM write %0d not one cycle after its strobe",
                             $time, i);
                    error_count++;
                end
            end
        end
        report_test("block RAM region", errors_before);
    endtask

    task automatic test_sdr_region();
        int          errors_before;
        logic [31:0] base;
        logic [15:0] word;
        errors_before = error_count;
        base = rom_loader_pkg::LOAD_REGIONS[1].base_addr;
        clear_logs();
        make_payload(16);
        send_region(8'd1, 24'd16);
        wait_idle();
        if (sdr_addr_log.size() != 8) begin
            $display("FAIL %0t: %0d SDRAM words, expected 8", $time, sdr_addr_log.size());
            error_count++;
        end else begin
            for (int n = 0; n < 8; n++) begin
                word = {payload[2*n+1], payload[2*n]};
                if (sdr_addr_log[n] !== 32'(base + 2*n) || sdr_data_log[n] !== word) begin
                    $display("FAIL %0t: SDRAM word %0d is %h=%h, expected %h=%h", $time, n,
                             sdr_addr_log[n], sdr_data_log[n], base + 2*n, word);
                    error_count++;
                end
            end
        end
        if (sdr_wait_low != 0) begin
            $display("FAIL %0t: ioctl_wait low during %0d SDRAM requests", $time, sdr_wait_low);
            error_count++;
        end
        report_test("SDRAM region", errors_before);
    endtask

    task automatic check_ddr_beats(input logic [31:0] base, input int beats);
        logic [63:0] beat;
        if (ddr_addr_log.size() != beats) begin
            $display("FAIL %0t: %0d DDR beats, expected %0d", $time, ddr_addr_log.size(), beats);
            error_count++;
        end else begin
            for (int n = 0; n < beats; n++) begin
                for (int k = 0; k < 8; k++) begin
                    beat[8*k +: 8] = payload[8*n+k];
                end
                if (ddr_addr_log[n] !== base + 8*n || ddr_data_log[n] !== beat) begin
                    $display("FAIL %0t: DDR beat %0d is %h=%h, expected %h=%h", $time, n,
                             ddr_addr_log[n], ddr_data_log[n], base + 8*n, beat);
                    error_count++;
                end
            end
        end
    endtask

    task automatic test_ddr_region();
        int errors_before;
        errors_before = error_count;
        clear_logs();
        make_payload(32);
        send_region(8'd2, 24'd32);
        wait_idle();
        check_ddr_beats(rom_loader_pkg::LOAD_REGIONS[2].base_addr, 4);
        if (stall_cycles == 0 || sdr_addr_log.size() != 0 || bram_addr_log.size() != 0) begin
            $display("FAIL %0t: DDR region stalled %0d cycles or wrote another memory",
                     $time, stall_cycles);
            error_count++;
        end
        report_test("DDR region", errors_before);
    endtask

    task automatic test_auto_increment();
        int          errors_before;
        logic [31:0] base;
        logic [7:0]  bram_bytes [$];
        errors_before = error_count;
        clear_logs();
        payload.delete();
        send_region(8'd3, 24'd0);
        // Index 0xFF steps to 4, then to 5
        make_payload(3);
        bram_bytes = payload;
        send_region(8'hff, 24'd3);
        make_payload(8);
        send_region(8'hff, 24'd8);
        wait_idle();
        base = rom_loader_pkg::LOAD_REGIONS[(3 + 1) % `NUM_REGIONS].base_addr;
        if (bram_addr_log.size() != 3) begin
            $display("FAIL %0t: %0d block RAM writes, expected 3", $time, bram_addr_log.size());
            error_count++;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (bram_addr_log[i] !== base + i || bram_data_log[i] !== bram_bytes[i]) begin
                    $display("FAIL %0t: block RAM write %0d is %h=%h, expected %h=%h", $time, i,
                             bram_addr_log[i], bram_data_log[i], base + i, bram_bytes[i]);
                    error_count++;
                end
            end
        end
        check_ddr_beats(rom_loader_pkg::LOAD_REGIONS[(3 + 2) % `NUM_REGIONS].base_addr, 1);
        report_test("auto-increment and zero size", errors_before);
    endtask

    initial begin
        void'($urandom(45879));
        clk          = 1'b0;
        reset        = 1'b1;
        ioctl_wr     = 1'b0;
        ioctl_data   = 8'h00;
        sdr_ack      = 1'b0;
        ddr_busy     = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_logs();
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;

        test_board_cfg();
        test_bram_region();
        test_sdr_region();
        test_ddr_region();
        test_auto_increment();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/rom_loader_pkg.sv
rtl/load_stream_if.sv
rtl/load_header_parser.sv
rtl/sdr_word_writer.sv
rtl/ddr_beat_writer.sv
rtl/rom_loader_top.sv
verif/tb_rom_loader.sv

// File: Bender.yml
package:
  name: rom_loader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rom_loader_pkg.sv
      - rtl/load_stream_if.sv
      - rtl/load_header_parser.sv
      - rtl/sdr_word_writer.sv
      - rtl/ddr_beat_writer.sv
      - rtl/rom_loader_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/tb_rom_loader.sv
